/* rtl/ctrl_macros.svh */
// sizes assume a 5-bit interrupt id; the cause word adds one interrupt flag bit above it
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// interrupt and cause word sizes
////////////////////////////////////////////////////////////////////////////

// interrupt id as delivered by the interrupt controller
`define CTRL_IRQ_ID_W 5

// cause word is the id plus the interrupt flag on top
`define CTRL_CAUSE_W (`CTRL_IRQ_ID_W + 1)

////////////////////////////////////////////////////////////////////////////
// controller FSM
////////////////////////////////////////////////////////////////////////////

// number of encoded states, anything at or above this is illegal
`define CTRL_STATE_N 8

`endif

/* rtl/ctrl_pkg.sv */
// types shared by the controller blocks; enum encodings must match the fetch stage and CSR file
`default_nettype none

package ctrl_pkg;

`include "ctrl_macros.svh"

  // fetch PC source
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_ERET
  } pc_sel_e;

  // exception vector select
  typedef enum logic [1:0] {
    EXC_PC_IRQ,
    EXC_PC_ECALL,
    EXC_PC_ILLINSN,
    EXC_PC_BREAKPOINT
  } exc_pc_sel_e;

  // synchronous exception codes, same width as an interrupt id
  typedef enum logic [`CTRL_IRQ_ID_W-1:0] {
    EXC_CODE_ILLEGAL_INSN = 2,
    EXC_CODE_BREAKPOINT   = 3,
    EXC_CODE_ECALL_MMODE  = 11
  } exc_code_e;

  // reduced instruction class seen by the FSM
  typedef enum logic [3:0] {
    KIND_NONE,
    KIND_JUMP,
    KIND_BRANCH,
    KIND_ECALL,
    KIND_ILLEGAL,
    KIND_MRET,
    KIND_EBREAK,
    KIND_WFI,
    KIND_CSR_FLUSH
  } insn_kind_e;

  // interrupt view of the cause word
  typedef struct packed {
    logic                      irq;
    logic [`CTRL_IRQ_ID_W-1:0] id;
  } cause_irq_t;

  // exception view of the cause word
  typedef struct packed {
    logic      irq;
    exc_code_e code;
  } cause_exc_t;

  // the CSR file tells the two apart by the top bit
  typedef union packed {
    cause_irq_t irq_v;
    cause_exc_t exc_v;
  } cause_u;

  // controller states
  typedef enum logic [3:0] {
    ST_RESET,
    ST_BOOT_SET,
    ST_WAIT_SLEEP,
    ST_SLEEP,
    ST_FIRST_FETCH,
    ST_DECODE,
    ST_FLUSH,
    ST_IRQ_TAKEN
  } ctrl_state_e;

  // what the FSM is doing this cycle
  typedef struct packed {
    ctrl_state_e               state;
    logic                      jump;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
  } ctrl_act_t;

  // redirect and CSR strobes towards fetch and the CSR file
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    cause_u      exc_cause;
    cause_u      csr_cause;
    logic        csr_save_if;
    logic        csr_save_id;
    logic        csr_save_cause;
    logic        csr_restore_mret;
  } ctrl_out_t;

endpackage

`default_nettype wire

/* rtl/ctrl_insn_classify.sv */
// decoder flags are trusted only while instr_valid_i is high; at most one exception flag at a time
`timescale 1ns/1ps
`default_nettype none

module ctrl_insn_classify (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  logic                   jump_set_i,
  input  logic                   branch_set_i,
  input  logic                   ecall_i,
  input  logic                   illegal_i,
  input  logic                   mret_i,
  input  logic                   ebreak_i,
  input  logic                   wfi_i,
  input  logic                   csr_status_i,
  input  logic                   capture_i,
  output ctrl_pkg::insn_kind_e   cur_kind_o,
  output ctrl_pkg::insn_kind_e   held_kind_o
);

  ctrl_pkg::insn_kind_e held_kind_q;

  ////////////////////////////////////////////////////////////////////////////
  // priority encoder
  ////////////////////////////////////////////////////////////////////////////

  // redirects first, then the flush kinds in decoder order
  always_comb begin
    cur_kind_o = ctrl_pkg::KIND_NONE;
    if (instr_valid_i) begin
      if (jump_set_i) begin
        cur_kind_o = ctrl_pkg::KIND_JUMP;
      end else if (branch_set_i) begin
        cur_kind_o = ctrl_pkg::KIND_BRANCH;
      end else if (ecall_i) begin
        cur_kind_o = ctrl_pkg::KIND_ECALL;
      end else if (illegal_i) begin
        cur_kind_o = ctrl_pkg::KIND_ILLEGAL;
      end else if (mret_i) begin
        cur_kind_o = ctrl_pkg::KIND_MRET;
      end else if (ebreak_i) begin
        cur_kind_o = ctrl_pkg::KIND_EBREAK;
      end else if (wfi_i) begin
        cur_kind_o = ctrl_pkg::KIND_WFI;
      end else if (csr_status_i) begin
        cur_kind_o = ctrl_pkg::KIND_CSR_FLUSH;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // held kind for the flush cycle
  ////////////////////////////////////////////////////////////////////////////

  // decoder may move on once the FSM has captured the kind
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      held_kind_q <= ctrl_pkg::KIND_NONE;
    end else if (capture_i) begin
      held_kind_q <= cur_kind_o;
    end
  end

  assign held_kind_o = held_kind_q;

  // exception flags from the decoder are mutually exclusive
  a_one_exc_flag : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> $onehot0({ecall_i, illegal_i, ebreak_i})
  );

endmodule

`default_nettype wire

/* rtl/ctrl_fsm.sv */
// interrupt request and id must stay stable until irq_ack_o; back-pressure only in first fetch
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_enable_i,
  input  logic                      id_ready_i,
  input  logic                      irq_i,
  input  logic                      irq_req_i,
  input  logic                      m_ie_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  ctrl_pkg::insn_kind_e      cur_kind_i,
  input  ctrl_pkg::insn_kind_e      held_kind_i,
  output logic                      capture_o,
  output logic                      instr_req_o,
  output logic                      ctrl_busy_o,
  output logic                      first_fetch_o,
  output logic                      is_decoding_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      irq_ack_o,
  output logic                      perf_jump_o,
  output logic                      perf_tbranch_o,
  output ctrl_pkg::ctrl_act_t       act_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;
  logic                  irq_take;
  logic                  is_redirect;
  logic                  is_special;
  logic                  jump_act;

  // interrupt is pending and machine mode allows it
  assign irq_take = irq_req_i & m_ie_i;

  // jumps redirect at once, the rest need a flush cycle
  assign is_redirect = (cur_kind_i == ctrl_pkg::KIND_JUMP) |
                       (cur_kind_i == ctrl_pkg::KIND_BRANCH);
  assign is_special  = (cur_kind_i != ctrl_pkg::KIND_NONE) & !is_redirect;

  ////////////////////////////////////////////////////////////////////////////
  // next state and control outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    capture_o      = 1'b0;
    instr_req_o    = 1'b1;
    ctrl_busy_o    = 1'b1;
    first_fetch_o  = 1'b0;
    is_decoding_o  = 1'b0;
    halt_if_o      = 1'b0;
    halt_id_o      = 1'b0;
    irq_ack_o      = 1'b0;
    perf_jump_o    = 1'b0;
    perf_tbranch_o = 1'b0;
    jump_act       = 1'b0;

    unique case (state_q)
      // idle until software lets the core run
      ctrl_pkg::ST_RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::ST_BOOT_SET;
        end
      end

      // boot address goes to fetch this cycle
      ctrl_pkg::ST_BOOT_SET: begin
        state_d = ctrl_pkg::ST_FIRST_FETCH;
      end

      // pipeline drains before the core sleeps
      ctrl_pkg::ST_WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::ST_SLEEP;
      end

      // any interrupt line wakes the core, even a masked one
      ctrl_pkg::ST_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (irq_i) begin
          state_d = ctrl_pkg::ST_FIRST_FETCH;
        end
      end

      // wait for the first word to reach ID
      ctrl_pkg::ST_FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = ctrl_pkg::ST_DECODE;
        end
        // interrupt beats the pending fetch
        if (irq_take) begin
          state_d   = ctrl_pkg::ST_IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      ctrl_pkg::ST_DECODE: begin
        if (irq_take) begin
          // instruction in ID is dropped and replayed after the handler
          state_d   = ctrl_pkg::ST_IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end else begin
          is_decoding_o = 1'b1;
          if (is_redirect) begin
            jump_act       = 1'b1;
            perf_jump_o    = (cur_kind_i == ctrl_pkg::KIND_JUMP);
            perf_tbranch_o = (cur_kind_i == ctrl_pkg::KIND_BRANCH);
          end else if (is_special) begin
            capture_o = 1'b1;
            state_d   = ctrl_pkg::ST_FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end
        end
      end

      // redirect for the held kind happens in the output block
      ctrl_pkg::ST_FLUSH: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (held_kind_i == ctrl_pkg::KIND_WFI) begin
          state_d = ctrl_pkg::ST_WAIT_SLEEP;
        end else begin
          state_d = ctrl_pkg::ST_DECODE;
        end
      end

      // single-cycle ack closes the request handshake
      ctrl_pkg::ST_IRQ_TAKEN: begin
        irq_ack_o = 1'b1;
        state_d   = ctrl_pkg::ST_DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::ST_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ctrl_pkg::ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // action for the output side
  assign act_o.state  = state_q;
  assign act_o.jump   = jump_act;
  assign act_o.irq_id = irq_id_i;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // requester must see a single ack pulse per interrupt
  a_ack_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o
  );

  // state register stays inside the encoded set
  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q < `CTRL_STATE_N
  );

endmodule

`default_nettype wire

/* rtl/ctrl_exc_out.sv */
// purely combinational; the held kind is only meaningful while the FSM sits in flush
`timescale 1ns/1ps
`default_nettype none

module ctrl_exc_out (
  input  ctrl_pkg::ctrl_act_t  act_i,
  input  ctrl_pkg::insn_kind_e held_kind_i,
  output ctrl_pkg::ctrl_out_t  out_o
);

  ////////////////////////////////////////////////////////////////////////////
  // PC select, cause word and CSR strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // default is no redirect with both cause views zero
    out_o = '0;

    unique case (act_i.state)
      ctrl_pkg::ST_RESET,
      ctrl_pkg::ST_BOOT_SET: begin
        out_o.pc_set = 1'b1;
        out_o.pc_mux = ctrl_pkg::PC_BOOT;
      end

      // jump target comes from ID in the same cycle
      ctrl_pkg::ST_DECODE: begin
        if (act_i.jump) begin
          out_o.pc_set = 1'b1;
          out_o.pc_mux = ctrl_pkg::PC_JUMP;
        end
      end

      ctrl_pkg::ST_FLUSH: begin
        // synchronous traps save the PC of the faulting instruction
        if (held_kind_i inside {ctrl_pkg::KIND_ECALL, ctrl_pkg::KIND_ILLEGAL,
                                ctrl_pkg::KIND_EBREAK}) begin
          out_o.pc_set         = 1'b1;
          out_o.pc_mux         = ctrl_pkg::PC_EXCEPTION;
          out_o.csr_save_id    = 1'b1;
          out_o.csr_save_cause = 1'b1;
        end
        unique case (held_kind_i)
          ctrl_pkg::KIND_ECALL: begin
            out_o.exc_pc_mux         = ctrl_pkg::EXC_PC_ECALL;
            out_o.exc_cause.exc_v.code = ctrl_pkg::EXC_CODE_ECALL_MMODE;
            out_o.csr_cause.exc_v.code = ctrl_pkg::EXC_CODE_ECALL_MMODE;
          end
          ctrl_pkg::KIND_ILLEGAL: begin
            out_o.exc_pc_mux         = ctrl_pkg::EXC_PC_ILLINSN;
            out_o.exc_cause.exc_v.code = ctrl_pkg::EXC_CODE_ILLEGAL_INSN;
            out_o.csr_cause.exc_v.code = ctrl_pkg::EXC_CODE_ILLEGAL_INSN;
          end
          // ebreak is a plain breakpoint trap here
          ctrl_pkg::KIND_EBREAK: begin
            out_o.exc_pc_mux         = ctrl_pkg::EXC_PC_BREAKPOINT;
            out_o.exc_cause.exc_v.code = ctrl_pkg::EXC_CODE_BREAKPOINT;
            out_o.csr_cause.exc_v.code = ctrl_pkg::EXC_CODE_BREAKPOINT;
          end
          // return to mepc and restore the interrupt enable
          ctrl_pkg::KIND_MRET: begin
            out_o.pc_set           = 1'b1;
            out_o.pc_mux           = ctrl_pkg::PC_ERET;
            out_o.csr_restore_mret = 1'b1;
          end
          // wfi and csr flush only stall
          default: begin
          end
        endcase
      end

      // handler entry saves the PC in IF as the return address
      ctrl_pkg::ST_IRQ_TAKEN: begin
        out_o.pc_set               = 1'b1;
        out_o.pc_mux               = ctrl_pkg::PC_EXCEPTION;
        out_o.exc_pc_mux           = ctrl_pkg::EXC_PC_IRQ;
        out_o.exc_cause.irq_v.id   = act_i.irq_id;
        out_o.csr_cause.irq_v.irq  = 1'b1;
        out_o.csr_cause.irq_v.id   = act_i.irq_id;
        out_o.csr_save_if          = 1'b1;
        out_o.csr_save_cause       = 1'b1;
      end

      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ctrl_top.sv */
// decoder flags are sampled in ID; interrupt request must be held as a level until the ack
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_enable_i,
  input  logic                      instr_valid_i,
  input  logic                      jump_set_i,
  input  logic                      branch_set_i,
  input  logic                      ecall_i,
  input  logic                      illegal_i,
  input  logic                      mret_i,
  input  logic                      ebreak_i,
  input  logic                      wfi_i,
  input  logic                      csr_status_i,
  input  logic                      id_ready_i,
  input  logic                      irq_i,
  input  logic                      irq_req_i,
  input  logic                      m_ie_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  output logic                      instr_req_o,
  output logic                      ctrl_busy_o,
  output logic                      first_fetch_o,
  output logic                      is_decoding_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      irq_ack_o,
  output logic                      perf_jump_o,
  output logic                      perf_tbranch_o,
  output ctrl_pkg::ctrl_out_t       ctrl_o
);

  ctrl_pkg::insn_kind_e cur_kind;
  ctrl_pkg::insn_kind_e held_kind;
  ctrl_pkg::ctrl_act_t  act;
  logic                 capture;

  // input side, flags to one kind
  ctrl_insn_classify u_classify (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .jump_set_i    (jump_set_i),
    .branch_set_i  (branch_set_i),
    .ecall_i       (ecall_i),
    .illegal_i     (illegal_i),
    .mret_i        (mret_i),
    .ebreak_i      (ebreak_i),
    .wfi_i         (wfi_i),
    .csr_status_i  (csr_status_i),
    .capture_i     (capture),
    .cur_kind_o    (cur_kind),
    .held_kind_o   (held_kind)
  );

  // control FSM
  ctrl_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready_i),
    .irq_i          (irq_i),
    .irq_req_i      (irq_req_i),
    .m_ie_i         (m_ie_i),
    .irq_id_i       (irq_id_i),
    .cur_kind_i     (cur_kind),
    .held_kind_i    (held_kind),
    .capture_o      (capture),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .irq_ack_o      (irq_ack_o),
    .perf_jump_o    (perf_jump_o),
    .perf_tbranch_o (perf_tbranch_o),
    .act_o          (act)
  );

  // output side, redirect and CSR bundle
  ctrl_exc_out u_exc_out (
    .act_i       (act),
    .held_kind_i (held_kind),
    .out_o       (ctrl_o)
  );

endmodule

`default_nettype wire

/* test/tb_ctrl.sv */
// run from the project root; each vector row is checked one falling edge after it is driven
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_macros.svh"

module tb_ctrl;

  // one line of the vector file with the inputs ahead of the expected outputs
  typedef struct packed {
    logic                      fetch_enable;
    logic                      instr_valid;
    logic                      jump_set;
    logic                      branch_set;
    logic                      ecall;
    logic                      illegal;
    logic                      mret;
    logic                      ebreak;
    logic                      wfi;
    logic                      csr_status;
    logic                      id_ready;
    logic                      irq;
    logic                      irq_req;
    logic                      m_ie;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
    logic                      exp_instr_req;
    logic                      exp_busy;
    logic                      exp_halt_id;
    logic                      exp_irq_ack;
    logic                      exp_pc_set;
    logic [1:0]                exp_pc_mux;
    logic [1:0]                exp_exc_pc_mux;
    logic [`CTRL_CAUSE_W-1:0]  exp_csr_cause;
    logic                      exp_perf_jump;
    logic                      exp_perf_tbranch;
  } vec_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      fetch_enable_i;
  logic                      instr_valid_i;
  logic                      jump_set_i;
  logic                      branch_set_i;
  logic                      ecall_i;
  logic                      illegal_i;
  logic                      mret_i;
  logic                      ebreak_i;
  logic                      wfi_i;
  logic                      csr_status_i;
  logic                      id_ready_i;
  logic                      irq_i;
  logic                      irq_req_i;
  logic                      m_ie_i;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i;
  logic                      instr_req_o;
  logic                      ctrl_busy_o;
  logic                      first_fetch_o;
  logic                      is_decoding_o;
  logic                      halt_if_o;
  logic                      halt_id_o;
  logic                      irq_ack_o;
  logic                      perf_jump_o;
  logic                      perf_tbranch_o;
  ctrl_pkg::ctrl_out_t       ctrl_o;

  vec_t vecs[$];
  int   errors;
  int   checks;
  int   cycles;
  int   limit;

  // what the previous row said about the controller state
  logic was_boot;
  logic was_asleep;
  logic was_first_fetch;
  logic was_decode;

  ctrl_top dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .jump_set_i     (jump_set_i),
    .branch_set_i   (branch_set_i),
    .ecall_i        (ecall_i),
    .illegal_i      (illegal_i),
    .mret_i         (mret_i),
    .ebreak_i       (ebreak_i),
    .wfi_i          (wfi_i),
    .csr_status_i   (csr_status_i),
    .id_ready_i     (id_ready_i),
    .irq_i          (irq_i),
    .irq_req_i      (irq_req_i),
    .m_ie_i         (m_ie_i),
    .irq_id_i       (irq_id_i),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .irq_ack_o      (irq_ack_o),
    .perf_jump_o    (perf_jump_o),
    .perf_tbranch_o (perf_tbranch_o),
    .ctrl_o         (ctrl_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  // run limit is set once the vectors are loaded
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("checks run: %0d, errors: %0d", checks, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // vector file and checking helpers
  ////////////////////////////////////////////////////////////////////////////

  // lines starting with # and blank lines are skipped
  task automatic load_vectors(output bit ok);
    int    fd;
    int    code;
    int    n;
    int    f[25];
    string line;
    vec_t  v;
    ok = 1'b1;
    fd = $fopen("test/ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open test/ctrl_tests.txt");
      ok = 1'b0;
    end else begin
      code = $fgets(line, fd);
      while (code != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line,
                      "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                      f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                      f[20], f[21], f[22], f[23], f[24]);
          if (n != 25) begin
            $display("malformed vector line, %0d fields read: %s", n, line);
            ok = 1'b0;
          end
          v.fetch_enable     = f[0][0];
          v.instr_valid      = f[1][0];
          v.jump_set         = f[2][0];
          v.branch_set       = f[3][0];
          v.ecall            = f[4][0];
          v.illegal          = f[5][0];
          v.mret             = f[6][0];
          v.ebreak           = f[7][0];
          v.wfi              = f[8][0];
          v.csr_status       = f[9][0];
          v.id_ready         = f[10][0];
          v.irq              = f[11][0];
          v.irq_req          = f[12][0];
          v.m_ie             = f[13][0];
          v.irq_id           = f[14][`CTRL_IRQ_ID_W-1:0];
          v.exp_instr_req    = f[15][0];
          v.exp_busy         = f[16][0];
          v.exp_halt_id      = f[17][0];
          v.exp_irq_ack      = f[18][0];
          v.exp_pc_set       = f[19][0];
          v.exp_pc_mux       = f[20][1:0];
          v.exp_exc_pc_mux   = f[21][1:0];
          v.exp_csr_cause    = f[22][`CTRL_CAUSE_W-1:0];
          v.exp_perf_jump    = f[23][0];
          v.exp_perf_tbranch = f[24][0];
          vecs.push_back(v);
        end
        code = $fgets(line, fd);
      end
      $fclose(fd);
      if (vecs.size() == 0) begin
        $display("no vectors found in test/ctrl_tests.txt");
        ok = 1'b0;
      end
    end
  endtask

  task automatic apply_inputs(input vec_t v);
    fetch_enable_i = v.fetch_enable;
    instr_valid_i  = v.instr_valid;
    jump_set_i     = v.jump_set;
    branch_set_i   = v.branch_set;
    ecall_i        = v.ecall;
    illegal_i      = v.illegal;
    mret_i         = v.mret;
    ebreak_i       = v.ebreak;
    wfi_i          = v.wfi;
    csr_status_i   = v.csr_status;
    id_ready_i     = v.id_ready;
    irq_i          = v.irq;
    irq_req_i      = v.irq_req;
    m_ie_i         = v.m_ie;
    irq_id_i       = v.irq_id;
  endtask

  task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    a_field : assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // strobes follow from the expected redirect and the cause flag
  // first fetch and decode are told apart by the row before
  task automatic check_outputs(input vec_t v);
    logic                     exc_redirect;
    logic                     exp_save_id;
    logic                     exp_save_if;
    logic                     exp_mret;
    logic                     irq_take;
    logic                     special;
    logic                     boot;
    logic                     flush;
    logic                     exp_ff;
    logic                     decode;
    logic [`CTRL_CAUSE_W-1:0] exp_exc_cause;
    exc_redirect = v.exp_pc_set && (v.exp_pc_mux == 2'd2);
    exp_save_id  = exc_redirect && !v.exp_csr_cause[`CTRL_CAUSE_W-1];
    exp_save_if  = exc_redirect && v.exp_csr_cause[`CTRL_CAUSE_W-1];
    exp_mret     = v.exp_pc_set && (v.exp_pc_mux == 2'd3);
    // enabled interrupt and flush-type instruction on this row's inputs
    irq_take = v.irq_req && v.m_ie;
    special  = v.instr_valid && !v.jump_set && !v.branch_set &&
               (v.ecall || v.illegal || v.mret || v.ebreak || v.wfi || v.csr_status);
    boot     = v.exp_instr_req && v.exp_pc_set && (v.exp_pc_mux == 2'd0);
    // first fetch after boot_set or a wake, held while ID is not ready
    exp_ff   = was_boot || (was_asleep && v.exp_busy) ||
               (was_first_fetch && !v.id_ready && !v.exp_irq_ack);
    flush    = was_decode && special && !irq_take;
    decode   = v.exp_instr_req && v.exp_busy && !v.exp_irq_ack && !boot && !exp_ff && !flush;
    // vector select sees the cause without the interrupt flag
    exp_exc_cause                  = v.exp_csr_cause;
    exp_exc_cause[`CTRL_CAUSE_W-1] = 1'b0;
    check_field("instr_req_o", instr_req_o, v.exp_instr_req);
    check_field("ctrl_busy_o", ctrl_busy_o, v.exp_busy);
    check_field("halt_id_o", halt_id_o, v.exp_halt_id);
    check_field("halt_if_o", halt_if_o, v.exp_halt_id);
    check_field("irq_ack_o", irq_ack_o, v.exp_irq_ack);
    check_field("first_fetch_o", first_fetch_o, exp_ff);
    check_field("is_decoding_o", is_decoding_o, decode && !irq_take);
    check_field("ctrl_o.pc_set", ctrl_o.pc_set, v.exp_pc_set);
    check_field("ctrl_o.pc_mux", ctrl_o.pc_mux, v.exp_pc_mux);
    check_field("ctrl_o.exc_pc_mux", ctrl_o.exc_pc_mux, v.exp_exc_pc_mux);
    check_field("ctrl_o.csr_cause", ctrl_o.csr_cause, v.exp_csr_cause);
    check_field("ctrl_o.exc_cause", ctrl_o.exc_cause, exp_exc_cause);
    check_field("perf_jump_o", perf_jump_o, v.exp_perf_jump);
    check_field("perf_tbranch_o", perf_tbranch_o, v.exp_perf_tbranch);
    check_field("ctrl_o.csr_save_id", ctrl_o.csr_save_id, exp_save_id);
    check_field("ctrl_o.csr_save_if", ctrl_o.csr_save_if, exp_save_if);
    check_field("ctrl_o.csr_save_cause", ctrl_o.csr_save_cause, exc_redirect);
    check_field("ctrl_o.csr_restore_mret", ctrl_o.csr_restore_mret, exp_mret);
    was_boot        = boot;
    was_asleep      = !v.exp_busy;
    was_first_fetch = exp_ff;
    was_decode      = decode;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    bit   ok;
    vec_t idle;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    errors          = 0;
    checks          = 0;
    cycles          = 0;
    limit           = 20;
    was_boot        = 1'b0;
    was_asleep      = 1'b0;
    was_first_fetch = 1'b0;
    was_decode      = 1'b0;
    idle            = '0;
    apply_inputs(idle);
    load_vectors(ok);
    if (!ok) begin
      $display("vector file could not be used, no checks run");
      $display("Testbench failed");
      $finish;
    end else begin
      limit = vecs.size() + 20;
      // three cycles of reset park the controller on the boot PC
      repeat (3) @(negedge clk_i);
      check_field("instr_req_o", instr_req_o, 1'b0);
      check_field("irq_ack_o", irq_ack_o, 1'b0);
      check_field("ctrl_o.pc_set", ctrl_o.pc_set, 1'b1);
      check_field("ctrl_o.pc_mux", ctrl_o.pc_mux, 2'd0);
      rst_ni = 1'b1;
      // each row is driven on a falling edge and sampled on the next one
      for (int i = 0; i < vecs.size(); i++) begin
        apply_inputs(vecs[i]);
        @(negedge clk_i);
        check_outputs(vecs[i]);
      end
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/ctrl_tests.txt */
# inputs: fe iv jmp br ecl ill mret ebk wfi csr rdy irq req mie id
# expect: req busy hid ack pcs pcm epm cause pj pb (all hex, sampled a cycle after driving)
# reset state, fetch disabled
0 0 0 0 0 0 0 0 0 0 0 0 0 0 00   0 1 0 0 1 0 0 00 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 00   0 1 0 0 1 0 0 00 0 0
# boot_set, first_fetch held by id_ready, then decode
1 0 0 0 0 0 0 0 0 0 0 0 0 0 00   1 1 0 0 1 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
# jump, taken branch
1 1 1 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 1 1 0 00 1 0
1 1 0 1 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 1 1 0 00 0 1
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
# ecall, illegal, ebreak, mret, csr flush
1 1 0 0 1 0 0 0 0 0 1 0 0 0 00   1 1 1 0 1 2 1 0b 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 1 0 0 0 1 0 0 0 0 1 0 0 0 00   1 1 1 0 1 2 2 02 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 1 0 0 0 0 0 1 0 0 1 0 0 0 00   1 1 1 0 1 2 3 03 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 1 0 0 0 0 1 0 0 0 1 0 0 0 00   1 1 1 0 1 3 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
1 1 0 0 0 0 0 0 0 1 1 0 0 0 00   1 1 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
# enabled interrupt, then one that beats a jump
1 0 0 0 0 0 0 0 0 0 1 0 1 1 07   1 1 0 1 1 2 0 27 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 1 00   1 1 0 0 0 0 0 00 0 0
1 1 1 0 0 0 0 0 0 0 1 0 1 1 1f   1 1 0 1 1 2 0 3f 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 1 00   1 1 0 0 0 0 0 00 0 0
# masked interrupt, never acked
1 0 0 0 0 0 0 0 0 0 1 0 1 0 05   1 1 0 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 1 0 05   1 1 0 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
# wfi, wait_sleep, sleep, wake on irq
1 1 0 0 0 0 0 0 1 0 1 0 0 0 00   1 1 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   0 0 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   0 0 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   0 0 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 1 0 0 00   1 1 0 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   1 1 0 0 0 0 0 00 0 0
# wfi woken by an enabled interrupt, taken from first_fetch
1 1 0 0 0 0 0 0 1 0 1 0 0 0 00   1 1 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   0 0 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 0 00   0 0 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 1 1 1 0b   1 1 1 0 0 0 0 00 0 0
1 0 0 0 0 0 0 0 0 0 1 1 1 1 0b   1 1 0 1 1 2 0 2b 0 0
1 0 0 0 0 0 0 0 0 0 1 0 0 1 00   1 1 0 0 0 0 0 00 0 0
1 1 1 0 0 0 0 0 0 0 1 0 0 1 00   1 1 0 0 1 1 0 00 1 0
1 0 0 0 0 0 0 0 0 0 1 0 0 1 00   1 1 0 0 0 0 0 00 0 0

/* all.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/ctrl_insn_classify.sv
rtl/ctrl_fsm.sv
rtl/ctrl_exc_out.sv
rtl/ctrl_top.sv
test/tb_ctrl.sv
